/* hdl/pscan_pkg.sv */
// widths, sizes and state enums shared by the page scan subsystem
`default_nettype none

package pscan_pkg;

    // word memory
    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;

    // burst length field holds beats minus one
    localparam int LEN_W = 4;

    // one page is 16 consecutive words
    localparam int PAGE_WORDS = 16;
    localparam int PAGE_W = 4;

    // read-burst buffer FIFO
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW = 4;

    typedef enum logic {
        HOLD_IDLE,
        HOLD_WAIT
    } hold_state_e;

    typedef enum logic [2:0] {
        SCAN_IDLE,
        SCAN_FLUSH,
        SCAN_ISSUE,
        SCAN_COLLECT,
        SCAN_DONE
    } scan_state_e;

    typedef enum logic [1:0] {
        GRANT_NONE,
        GRANT_SCAN,
        GRANT_HOST
    } grant_e;

endpackage

`default_nettype wire

/* hdl/read_burst_buffer.sv */
// read-burst buffer: address hold until FIFO room, burst data FIFO, output register
`timescale 1ns/1ps
`default_nettype none

module read_burst_buffer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdptr_rst,
    input  logic                          wrptr_rst,
    input  logic                          s_arvalid,
    output logic                          s_arready,
    input  logic [pscan_pkg::ADDR_W-1:0]  s_araddr,
    input  logic [pscan_pkg::LEN_W-1:0]   s_arlen,
    output logic                          s_rvalid,
    input  logic                          s_rready,
    output logic [pscan_pkg::DATA_W-1:0]  s_rdata,
    output logic                          s_rlast,
    output logic                          m_arvalid,
    input  logic                          m_arready,
    output logic [pscan_pkg::ADDR_W-1:0]  m_araddr,
    output logic [pscan_pkg::LEN_W-1:0]   m_arlen,
    input  logic                          m_rvalid,
    output logic                          m_rready,
    input  logic [pscan_pkg::DATA_W-1:0]  m_rdata,
    input  logic                          m_rlast
);

    pscan_pkg::hold_state_e state, state_next;

    // beats committed to the FIFO but not yet taken by the scanner
    logic [pscan_pkg::FIFO_AW:0]   count, count_next;
    logic [pscan_pkg::ADDR_W-1:0]  araddr_q, araddr_next;
    logic [pscan_pkg::LEN_W-1:0]   arlen_q, arlen_next;
    logic                          m_arvalid_q, m_arvalid_next;
    logic                          s_arready_q, s_arready_next;
    logic                          fits_new, fits_held;

    logic [pscan_pkg::FIFO_AW:0]   wr_ptr, rd_ptr;
    logic [pscan_pkg::DATA_W:0]    fifo_mem [pscan_pkg::FIFO_DEPTH];
    logic [pscan_pkg::DATA_W:0]    mem_rd_data, out_data;
    logic                          mem_rd_valid, out_valid;
    logic                          fifo_full, fifo_empty;
    logic                          fifo_write, fifo_read;

    assign fits_new = (count == '0) ||
                      (int'(count) + int'(s_arlen) + 1 <= pscan_pkg::FIFO_DEPTH);
    assign fits_held = (count == '0) ||
                       (int'(count) + int'(arlen_q) + 1 <= pscan_pkg::FIFO_DEPTH);

    always_comb begin
        state_next = state;
        count_next = count;
        araddr_next = araddr_q;
        arlen_next = arlen_q;
        m_arvalid_next = m_arvalid_q && !m_arready;
        s_arready_next = s_arready_q;

        case (state)
            pscan_pkg::HOLD_IDLE: begin
                s_arready_next = !m_arvalid_q;
                if (s_arvalid && s_arready_q) begin
                    s_arready_next = 1'b0;
                    araddr_next = s_araddr;
                    arlen_next = s_arlen;
                    if (fits_new) begin
                        count_next = count + (pscan_pkg::FIFO_AW + 1)'(s_arlen) + 1'b1;
                        m_arvalid_next = 1'b1;
                    end else begin
                        state_next = pscan_pkg::HOLD_WAIT;
                    end
                end
            end
            pscan_pkg::HOLD_WAIT: begin
                s_arready_next = 1'b0;
                if (fits_held) begin
                    count_next = count + (pscan_pkg::FIFO_AW + 1)'(arlen_q) + 1'b1;
                    m_arvalid_next = 1'b1;
                    state_next = pscan_pkg::HOLD_IDLE;
                end
            end
            default: state_next = pscan_pkg::HOLD_IDLE;
        endcase

        // beat leaving toward the scanner frees one slot
        if (s_rvalid && s_rready) begin
            count_next = count_next - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pscan_pkg::HOLD_IDLE;
            count <= '0;
            m_arvalid_q <= 1'b0;
            s_arready_q <= 1'b0;
        end else begin
            state <= state_next;
            count <= count_next;
            m_arvalid_q <= m_arvalid_next;
            s_arready_q <= s_arready_next;
        end
        araddr_q <= araddr_next;
        arlen_q <= arlen_next;
    end

    assign s_arready = s_arready_q;
    assign m_arvalid = m_arvalid_q;
    assign m_araddr = araddr_q;
    assign m_arlen = arlen_q;

    // pointers carry one extra wrap bit
    assign fifo_full = (wr_ptr[pscan_pkg::FIFO_AW] != rd_ptr[pscan_pkg::FIFO_AW]) &&
                       (wr_ptr[pscan_pkg::FIFO_AW-1:0] == rd_ptr[pscan_pkg::FIFO_AW-1:0]);
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_write = m_rvalid && !fifo_full;
    assign fifo_read = s_rready && !fifo_empty;
    assign m_rready = !fifo_full;

    always_ff @(posedge clk) begin
        if (rst || wrptr_rst) begin
            wr_ptr <= '0;
        end else if (fifo_write) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (fifo_write) begin
            fifo_mem[wr_ptr[pscan_pkg::FIFO_AW-1:0]] <= {m_rlast, m_rdata};
        end
    end

    // read stage and output register both advance only when the scanner is ready
    always_ff @(posedge clk) begin
        if (rst || rdptr_rst) begin
            rd_ptr <= '0;
            mem_rd_valid <= 1'b0;
        end else if (s_rready) begin
            mem_rd_valid <= !fifo_empty;
            if (!fifo_empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (s_rready) begin
            out_valid <= mem_rd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_read) begin
            mem_rd_data <= fifo_mem[rd_ptr[pscan_pkg::FIFO_AW-1:0]];
        end
        if (s_rready) begin
            out_data <= mem_rd_data;
        end
    end

    assign s_rvalid = out_valid;
    assign s_rdata = out_data[pscan_pkg::DATA_W-1:0];
    assign s_rlast = out_data[pscan_pkg::DATA_W];

endmodule

`default_nettype wire

/* hdl/page_scanner.sv */
// page scan engine: four-phase scan handshake, zero-word count and XOR checksum
`timescale 1ns/1ps
`default_nettype none

module page_scanner (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          scan_req,
    input  logic [pscan_pkg::PAGE_W-1:0]  scan_page,
    output logic                          scan_ack,
    output logic [4:0]                    scan_zero_count,
    output logic [pscan_pkg::DATA_W-1:0]  scan_checksum,
    output logic                          rdptr_rst,
    output logic                          wrptr_rst,
    output logic                          arvalid,
    input  logic                          arready,
    output logic [pscan_pkg::ADDR_W-1:0]  araddr,
    output logic [pscan_pkg::LEN_W-1:0]   arlen,
    input  logic                          rvalid,
    output logic                          rready,
    input  logic [pscan_pkg::DATA_W-1:0]  rdata,
    input  logic                          rlast
);

    pscan_pkg::scan_state_e state;

    logic [pscan_pkg::PAGE_W-1:0]  page_q;
    logic [4:0]                    zero_cnt;
    logic [pscan_pkg::DATA_W-1:0]  xor_acc;
    logic                          beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= pscan_pkg::SCAN_IDLE;
        end else begin
            case (state)
                pscan_pkg::SCAN_IDLE:    if (scan_req) state <= pscan_pkg::SCAN_FLUSH;
                pscan_pkg::SCAN_FLUSH:   state <= pscan_pkg::SCAN_ISSUE;
                pscan_pkg::SCAN_ISSUE:   if (arready) state <= pscan_pkg::SCAN_COLLECT;
                pscan_pkg::SCAN_COLLECT: if (beat && rlast) state <= pscan_pkg::SCAN_DONE;
                pscan_pkg::SCAN_DONE:    if (!scan_req) state <= pscan_pkg::SCAN_IDLE;
                default:                 state <= pscan_pkg::SCAN_IDLE;
            endcase
        end
    end

    // only beats of the new burst count; anything earlier is flushed stale data
    assign beat = (state == pscan_pkg::SCAN_COLLECT) && rvalid;

    always_ff @(posedge clk) begin
        if (state == pscan_pkg::SCAN_IDLE && scan_req) begin
            page_q <= scan_page;
        end
        if (state == pscan_pkg::SCAN_FLUSH) begin
            zero_cnt <= '0;
            xor_acc <= '0;
        end else if (beat) begin
            zero_cnt <= zero_cnt + 5'(rdata == '0);
            xor_acc <= xor_acc ^ rdata;
        end
    end

    // both buffer pointers restart together for a fresh page
    assign rdptr_rst = (state == pscan_pkg::SCAN_FLUSH);
    assign wrptr_rst = (state == pscan_pkg::SCAN_FLUSH);

    assign arvalid = (state == pscan_pkg::SCAN_ISSUE);
    assign araddr = {page_q, {(pscan_pkg::ADDR_W - pscan_pkg::PAGE_W){1'b0}}};
    assign arlen = pscan_pkg::LEN_W'(pscan_pkg::PAGE_WORDS - 1);
    assign rready = (state == pscan_pkg::SCAN_FLUSH) || (state == pscan_pkg::SCAN_ISSUE) ||
                    (state == pscan_pkg::SCAN_COLLECT);

    assign scan_ack = (state == pscan_pkg::SCAN_DONE);
    assign scan_zero_count = zero_cnt;
    assign scan_checksum = xor_acc;

endmodule

`default_nettype wire

/* hdl/read_arbiter.sv */
// round-robin arbiter placing two burst readers on one memory read channel
`timescale 1ns/1ps
`default_nettype none

module read_arbiter (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          p0_arvalid,
    output logic                          p0_arready,
    input  logic [pscan_pkg::ADDR_W-1:0]  p0_araddr,
    input  logic [pscan_pkg::LEN_W-1:0]   p0_arlen,
    output logic                          p0_rvalid,
    input  logic                          p0_rready,
    output logic [pscan_pkg::DATA_W-1:0]  p0_rdata,
    output logic                          p0_rlast,
    input  logic                          p1_arvalid,
    output logic                          p1_arready,
    input  logic [pscan_pkg::ADDR_W-1:0]  p1_araddr,
    input  logic [pscan_pkg::LEN_W-1:0]   p1_arlen,
    output logic                          p1_rvalid,
    input  logic                          p1_rready,
    output logic [pscan_pkg::DATA_W-1:0]  p1_rdata,
    output logic                          p1_rlast,
    output logic                          mem_arvalid,
    input  logic                          mem_arready,
    output logic [pscan_pkg::ADDR_W-1:0]  mem_araddr,
    output logic [pscan_pkg::LEN_W-1:0]   mem_arlen,
    input  logic                          mem_rvalid,
    output logic                          mem_rready,
    input  logic [pscan_pkg::DATA_W-1:0]  mem_rdata,
    input  logic                          mem_rlast
);

    pscan_pkg::grant_e grant;

    // set when the host port won the previous round
    logic last_host;
    logic scan_sel, host_sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= pscan_pkg::GRANT_NONE;
            last_host <= 1'b0;
        end else if (grant == pscan_pkg::GRANT_NONE) begin
            if (p0_arvalid && (!p1_arvalid || last_host)) begin
                grant <= pscan_pkg::GRANT_SCAN;
                last_host <= 1'b0;
            end else if (p1_arvalid) begin
                grant <= pscan_pkg::GRANT_HOST;
                last_host <= 1'b1;
            end
        end else if (mem_rvalid && mem_rready && mem_rlast) begin
            grant <= pscan_pkg::GRANT_NONE;
        end
    end

    assign scan_sel = (grant == pscan_pkg::GRANT_SCAN);
    assign host_sel = (grant == pscan_pkg::GRANT_HOST);

    assign mem_arvalid = (scan_sel && p0_arvalid) || (host_sel && p1_arvalid);
    assign mem_araddr = host_sel ? p1_araddr : p0_araddr;
    assign mem_arlen = host_sel ? p1_arlen : p0_arlen;
    assign mem_rready = (scan_sel && p0_rready) || (host_sel && p1_rready);

    assign p0_arready = scan_sel && mem_arready;
    assign p0_rvalid = scan_sel && mem_rvalid;
    assign p0_rdata = scan_sel ? mem_rdata : '0;
    assign p0_rlast = scan_sel && mem_rlast;

    assign p1_arready = host_sel && mem_arready;
    assign p1_rvalid = host_sel && mem_rvalid;
    assign p1_rdata = host_sel ? mem_rdata : '0;
    assign p1_rlast = host_sel && mem_rlast;

endmodule

`default_nettype wire

/* hdl/page_memory.sv */
// 256-word memory with host write port and burst read channel
`timescale 1ns/1ps
`default_nettype none

module page_memory (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en,
    input  logic [pscan_pkg::ADDR_W-1:0]  wr_addr,
    input  logic [pscan_pkg::DATA_W-1:0]  wr_data,
    input  logic                          arvalid,
    output logic                          arready,
    input  logic [pscan_pkg::ADDR_W-1:0]  araddr,
    input  logic [pscan_pkg::LEN_W-1:0]   arlen,
    output logic                          rvalid,
    input  logic                          rready,
    output logic [pscan_pkg::DATA_W-1:0]  rdata,
    output logic                          rlast
);

    logic [pscan_pkg::DATA_W-1:0]  mem [2**pscan_pkg::ADDR_W];
    logic [pscan_pkg::ADDR_W-1:0]  next_addr;
    logic [pscan_pkg::LEN_W-1:0]   beats_left;
    logic                          ar_fire, r_fire;

    assign ar_fire = arvalid && arready;
    assign r_fire = rvalid && rready;

    // rvalid doubles as the burst-active flag
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            arready <= 1'b0;
            rvalid <= 1'b1;
        end else if (r_fire && rlast) begin
            rvalid <= 1'b0;
            arready <= 1'b1;
        end else if (!rvalid) begin
            arready <= 1'b1;
        end
    end

    // address wraps at the top of memory
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (ar_fire) begin
            rdata <= mem[araddr];
            rlast <= (arlen == '0);
            next_addr <= araddr + 1'b1;
            beats_left <= arlen;
        end else if (r_fire && !rlast) begin
            rdata <= mem[next_addr];
            rlast <= (beats_left == 1);
            next_addr <= next_addr + 1'b1;
            beats_left <= beats_left - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/pscan_top.sv */
// top level: page scanner, read-burst buffer, read arbiter and page memory
`timescale 1ns/1ps
`default_nettype none

module pscan_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          wr_en,
    input  logic [pscan_pkg::ADDR_W-1:0]  wr_addr,
    input  logic [pscan_pkg::DATA_W-1:0]  wr_data,
    input  logic                          scan_req,
    input  logic [pscan_pkg::PAGE_W-1:0]  scan_page,
    output logic                          scan_ack,
    output logic [4:0]                    scan_zero_count,
    output logic [pscan_pkg::DATA_W-1:0]  scan_checksum,
    input  logic                          host_arvalid,
    output logic                          host_arready,
    input  logic [pscan_pkg::ADDR_W-1:0]  host_araddr,
    input  logic [pscan_pkg::LEN_W-1:0]   host_arlen,
    output logic                          host_rvalid,
    input  logic                          host_rready,
    output logic [pscan_pkg::DATA_W-1:0]  host_rdata,
    output logic                          host_rlast
);

    // scanner to buffer
    logic                          rdptr_rst, wrptr_rst;
    logic                          sc_arvalid, sc_arready, sc_rvalid, sc_rready, sc_rlast;
    logic [pscan_pkg::ADDR_W-1:0]  sc_araddr;
    logic [pscan_pkg::LEN_W-1:0]   sc_arlen;
    logic [pscan_pkg::DATA_W-1:0]  sc_rdata;

    // buffer to arbiter port 0
    logic                          bf_arvalid, bf_arready, bf_rvalid, bf_rready, bf_rlast;
    logic [pscan_pkg::ADDR_W-1:0]  bf_araddr;
    logic [pscan_pkg::LEN_W-1:0]   bf_arlen;
    logic [pscan_pkg::DATA_W-1:0]  bf_rdata;

    // arbiter to memory
    logic                          mem_arvalid, mem_arready, mem_rvalid, mem_rready, mem_rlast;
    logic [pscan_pkg::ADDR_W-1:0]  mem_araddr;
    logic [pscan_pkg::LEN_W-1:0]   mem_arlen;
    logic [pscan_pkg::DATA_W-1:0]  mem_rdata;

    page_scanner u_scanner (
        .clk(clk), .rst(rst),
        .scan_req(scan_req), .scan_page(scan_page), .scan_ack(scan_ack),
        .scan_zero_count(scan_zero_count), .scan_checksum(scan_checksum),
        .rdptr_rst(rdptr_rst), .wrptr_rst(wrptr_rst),
        .arvalid(sc_arvalid), .arready(sc_arready), .araddr(sc_araddr), .arlen(sc_arlen),
        .rvalid(sc_rvalid), .rready(sc_rready), .rdata(sc_rdata), .rlast(sc_rlast)
    );

    read_burst_buffer u_buffer (
        .clk(clk), .rst(rst), .rdptr_rst(rdptr_rst), .wrptr_rst(wrptr_rst),
        .s_arvalid(sc_arvalid), .s_arready(sc_arready),
        .s_araddr(sc_araddr), .s_arlen(sc_arlen),
        .s_rvalid(sc_rvalid), .s_rready(sc_rready), .s_rdata(sc_rdata), .s_rlast(sc_rlast),
        .m_arvalid(bf_arvalid), .m_arready(bf_arready),
        .m_araddr(bf_araddr), .m_arlen(bf_arlen),
        .m_rvalid(bf_rvalid), .m_rready(bf_rready), .m_rdata(bf_rdata), .m_rlast(bf_rlast)
    );

    read_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .p0_arvalid(bf_arvalid), .p0_arready(bf_arready),
        .p0_araddr(bf_araddr), .p0_arlen(bf_arlen),
        .p0_rvalid(bf_rvalid), .p0_rready(bf_rready), .p0_rdata(bf_rdata), .p0_rlast(bf_rlast),
        .p1_arvalid(host_arvalid), .p1_arready(host_arready),
        .p1_araddr(host_araddr), .p1_arlen(host_arlen),
        .p1_rvalid(host_rvalid), .p1_rready(host_rready),
        .p1_rdata(host_rdata), .p1_rlast(host_rlast),
        .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
        .mem_araddr(mem_araddr), .mem_arlen(mem_arlen),
        .mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
        .mem_rdata(mem_rdata), .mem_rlast(mem_rlast)
    );

    page_memory u_memory (
        .clk(clk), .rst(rst),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .arvalid(mem_arvalid), .arready(mem_arready), .araddr(mem_araddr), .arlen(mem_arlen),
        .rvalid(mem_rvalid), .rready(mem_rready), .rdata(mem_rdata), .rlast(mem_rlast)
    );

endmodule

`default_nettype wire

/* test/pscan_assertions.sv */
// protocol assertions on the scan handshake, host read channel and memory channel
`timescale 1ns/1ps
`default_nettype none

module pscan_assertions (
    input logic                          clk,
    input logic                          rst,
    input logic                          scan_req,
    input logic                          scan_ack,
    input logic                          host_rvalid,
    input logic                          host_rready,
    input logic [pscan_pkg::DATA_W-1:0]  host_rdata,
    input logic                          host_rlast,
    input logic                          mem_arvalid,
    input logic                          mem_rvalid
);

    // ack only drops after the request is withdrawn
    ack_hold: assert property (@(posedge clk) disable iff (rst)
        scan_req && scan_ack |=> scan_ack)
        else $error("scan_ack fell while scan_req was high");

    // a stalled host beat keeps its payload
    host_beat_stable: assert property (@(posedge clk) disable iff (rst)
        host_rvalid && !host_rready |=>
            host_rvalid && $stable(host_rdata) && $stable(host_rlast))
        else $error("host read beat changed while stalled");

    // memory rvalid marks an active burst
    no_addr_in_burst: assert property (@(posedge clk) disable iff (rst)
        !(mem_arvalid && mem_rvalid))
        else $error("memory address offered during an active burst");

endmodule

bind pscan_top pscan_assertions u_assertions (
    .clk(clk), .rst(rst),
    .scan_req(scan_req), .scan_ack(scan_ack),
    .host_rvalid(host_rvalid), .host_rready(host_rready),
    .host_rdata(host_rdata), .host_rlast(host_rlast),
    .mem_arvalid(mem_arvalid), .mem_rvalid(mem_rvalid)
);

`default_nettype wire

/* test/tb_pscan_top.sv */
// testbench for pscan_top: LFSR stimulus, shadow memory, reference model, checks and report
`timescale 1ns/1ps
`default_nettype none

module tb_pscan_top;

    localparam int WAIT_LIMIT = 200;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          wr_en;
    logic [pscan_pkg::ADDR_W-1:0]  wr_addr;
    logic [pscan_pkg::DATA_W-1:0]  wr_data;
    logic                          scan_req;
    logic [pscan_pkg::PAGE_W-1:0]  scan_page;
    logic                          scan_ack;
    logic [4:0]                    scan_zero_count;
    logic [pscan_pkg::DATA_W-1:0]  scan_checksum;
    logic                          host_arvalid, host_arready;
    logic [pscan_pkg::ADDR_W-1:0]  host_araddr;
    logic [pscan_pkg::LEN_W-1:0]   host_arlen;
    logic                          host_rvalid, host_rready, host_rlast;
    logic [pscan_pkg::DATA_W-1:0]  host_rdata;

    // copy of every word written into the DUT memory
    logic [pscan_pkg::DATA_W-1:0]  shadow [2**pscan_pkg::ADDR_W];
    logic [15:0]                   lfsr_state = 16'd35;
    int                            errors = 0;
    int                            checks = 0;
    int                            tests = 0;
    int                            test_errors = 0;

    always #5 clk = ~clk;

    pscan_top u_dut (
        .clk(clk), .rst(rst),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .scan_req(scan_req), .scan_page(scan_page), .scan_ack(scan_ack),
        .scan_zero_count(scan_zero_count), .scan_checksum(scan_checksum),
        .host_arvalid(host_arvalid), .host_arready(host_arready),
        .host_araddr(host_araddr), .host_arlen(host_arlen),
        .host_rvalid(host_rvalid), .host_rready(host_rready),
        .host_rdata(host_rdata), .host_rlast(host_rlast)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [pscan_pkg::ADDR_W-1:0] page_addr(
        input logic [pscan_pkg::PAGE_W-1:0] page, input int i);
        return pscan_pkg::ADDR_W'(int'(page) * pscan_pkg::PAGE_WORDS + i);
    endfunction

    function automatic logic [4:0] ref_zero_count(input logic [pscan_pkg::PAGE_W-1:0] page);
        logic [4:0] n;
        n = '0;
        for (int i = 0; i < pscan_pkg::PAGE_WORDS; i++) begin
            if (shadow[page_addr(page, i)] == '0)
                n++;
        end
        return n;
    endfunction

    function automatic logic [pscan_pkg::DATA_W-1:0] ref_checksum(
        input logic [pscan_pkg::PAGE_W-1:0] page);
        logic [pscan_pkg::DATA_W-1:0] x;
        x = '0;
        for (int i = 0; i < pscan_pkg::PAGE_WORDS; i++)
            x = x ^ shadow[page_addr(page, i)];
        return x;
    endfunction

    task automatic check_word(input logic [pscan_pkg::DATA_W-1:0] got,
                              input logic [pscan_pkg::DATA_W-1:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input logic [4:0] got, input logic [4:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s: got %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s: got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout: %s within %0d cycles", what, WAIT_LIMIT);
    endtask

    task automatic start_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_errors)
            $display("test %0d, %s: ok", tests, name);
        else
            $display("test %0d, %s: %0d errors", tests, name, errors - test_errors);
    endtask

    task automatic write_word(input logic [pscan_pkg::ADDR_W-1:0] addr,
                              input logic [pscan_pkg::DATA_W-1:0] data);
        @(negedge clk);
        wr_en = 1'b1;
        wr_addr = addr;
        wr_data = data;
        shadow[addr] = data;
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // random words, about a quarter of them forced to zero
    task automatic write_page(input logic [pscan_pkg::PAGE_W-1:0] page, input bit all_zero);
        logic [pscan_pkg::DATA_W-1:0] d;
        for (int i = 0; i < pscan_pkg::PAGE_WORDS; i++) begin
            d = rand_bits(32);
            if (all_zero || rand_bits(2) == 0)
                d = '0;
            write_word(page_addr(page, i), d);
        end
    endtask

    task automatic host_read(input logic [pscan_pkg::ADDR_W-1:0] addr,
                             input logic [pscan_pkg::LEN_W-1:0] len, input bit stall);
        logic [pscan_pkg::ADDR_W-1:0] a;
        int beats;
        int waited;
        a = addr;
        beats = 0;
        waited = 0;
        @(negedge clk);
        host_arvalid = 1'b1;
        host_araddr = addr;
        host_arlen = len;
        while (!host_arready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("host read address was not accepted");
                host_arvalid = 1'b0;
                return;
            end
        end
        @(negedge clk);
        host_arvalid = 1'b0;
        waited = 0;
        while (beats <= int'(len)) begin
            host_rready = stall ? (rand_bits(1) != 0) : 1'b1;
            if (host_rvalid && host_rready) begin
                check_word(host_rdata, shadow[a], $sformatf("host beat %0d at %h", beats, a));
                check_flag(host_rlast, beats == int'(len), $sformatf("host rlast beat %0d", beats));
                a++;
                beats++;
                waited = 0;
            end else begin
                waited++;
                if (waited > WAIT_LIMIT) begin
                    report_timeout("host read beats did not arrive");
                    host_rready = 1'b0;
                    return;
                end
            end
            @(negedge clk);
        end
        host_rready = 1'b0;
        check_flag(host_rvalid, 1'b0, "host rvalid after the last beat");
    endtask

    task automatic run_scan(input logic [pscan_pkg::PAGE_W-1:0] page, input int hold);
        logic [4:0] exp_count;
        logic [pscan_pkg::DATA_W-1:0] exp_sum;
        int waited;
        exp_count = ref_zero_count(page);
        exp_sum = ref_checksum(page);
        waited = 0;
        @(negedge clk);
        scan_req = 1'b1;
        scan_page = page;
        while (!scan_ack) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("scan_ack did not rise");
                scan_req = 1'b0;
                return;
            end
        end
        check_count(scan_zero_count, exp_count, $sformatf("zero count of page %0d", page));
        check_word(scan_checksum, exp_sum, $sformatf("checksum of page %0d", page));
        // results must hold for as long as the request stays up
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            check_flag(scan_ack, 1'b1, "scan_ack while scan_req high");
            check_word(scan_checksum, exp_sum, "checksum while acknowledged");
        end
        scan_req = 1'b0;
        @(negedge clk);
        check_flag(scan_ack, 1'b0, "scan_ack one cycle after scan_req fell");
        waited = 0;
        while (scan_ack) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("scan_ack did not fall");
                return;
            end
        end
    endtask

    initial begin
        logic [pscan_pkg::PAGE_W-1:0] pg;
        logic [pscan_pkg::ADDR_W-1:0] ra;
        rst = 1'b1;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        scan_req = 1'b0;
        scan_page = '0;
        host_arvalid = 1'b0;
        host_araddr = '0;
        host_arlen = '0;
        host_rready = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        start_test();
        for (int a = 0; a < 2**pscan_pkg::ADDR_W; a++)
            write_word(pscan_pkg::ADDR_W'(a), rand_bits(32));
        host_read(pscan_pkg::ADDR_W'(rand_bits(8)), 4'd7, 1'b0);
        end_test("host burst read of 8 words");

        start_test();
        pg = pscan_pkg::PAGE_W'(rand_bits(4));
        write_page(pg, 1'b1);
        run_scan(pg, 0);
        end_test("scan of an all-zero page");

        start_test();
        repeat (4) begin
            pg = pscan_pkg::PAGE_W'(rand_bits(4));
            write_page(pg, 1'b0);
            run_scan(pg, 0);
        end
        end_test("scans of random pages");

        start_test();
        pg = pscan_pkg::PAGE_W'(rand_bits(4));
        ra = pscan_pkg::ADDR_W'(rand_bits(8));
        fork
            host_read(ra, 4'd7, 1'b0);
            run_scan(pg, 0);
        join
        end_test("host read and scan in the same cycle");

        start_test();
        host_read(pscan_pkg::ADDR_W'(rand_bits(8)), 4'd15, 1'b1);
        end_test("host read with rready stalls");

        start_test();
        pg = pscan_pkg::PAGE_W'(rand_bits(4));
        write_page(pg, 1'b0);
        write_page(pg + 1'b1, 1'b0);
        run_scan(pg, 4);
        run_scan(pg + 1'b1, 0);
        end_test("scan handshake and back-to-back scan");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
hdl/pscan_pkg.sv
hdl/read_burst_buffer.sv
hdl/page_scanner.sv
hdl/read_arbiter.sv
hdl/page_memory.sv
hdl/pscan_top.sv
test/pscan_assertions.sv
test/tb_pscan_top.sv

/* run.sh */
#!/usr/bin/env bash
# compile the page scan testbench with Verilator, run it and search the log for the fail message
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pscan_top -f build.f \
    && ./obj_dir/Vtb_pscan_top 2>&1 | tee sim.log \
    || { echo "simulation failed to build or stopped early"; exit 1; }
grep -q "Done: errors found" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
